// File: dv/mps_core_sva.sv
`timescale 1ns/100ps

module mps_core_sva
	import mps_pkg::*;
(
	input logic       s00_axi_aclk,
	input logic       s00_axi_aresetn,
	input logic       o_s00_axi_awready,
	input logic       o_s00_axi_bvalid,
	input logic       i_s00_axi_bready,
	input logic       o_s00_axi_rvalid,
	input logic       i_s00_axi_rready,
	input adc_word_t  o_s00_axi_rdata,
	input logic [2:0] o_phase_rms_valid
);

	// Write response waits for BREADY
	bvalid_hold: assert property (@(posedge s00_axi_aclk) disable iff (!s00_axi_aresetn)
		o_s00_axi_bvalid && !i_s00_axi_bready |=> o_s00_axi_bvalid)
		else $error("BVALID dropped before BREADY");

	// Read data frozen until taken
	rvalid_hold: assert property (@(posedge s00_axi_aclk) disable iff (!s00_axi_aresetn)
		o_s00_axi_rvalid && !i_s00_axi_rready |=> o_s00_axi_rvalid && $stable(o_s00_axi_rdata))
		else $error("RVALID or RDATA changed before RREADY");

	rms_pulse: assert property (@(posedge s00_axi_aclk) disable iff (!s00_axi_aresetn)
		(o_phase_rms_valid != 3'b000) |=> ((o_phase_rms_valid & $past(o_phase_rms_valid)) == 3'b000))
		else $error("RMS valid longer than one cycle");

	no_accept_busy: assert property (@(posedge s00_axi_aclk) disable iff (!s00_axi_aresetn)
		o_s00_axi_bvalid |-> !o_s00_axi_awready)
		else $error("AWREADY high while BVALID pending");

endmodule

// File: dv/mps_core_tb.sv
`timescale 1ns/100ps

module mps_core_tb
	import mps_pkg::*;
();

	localparam int WAIT_LIMIT = 200;
	localparam int RMS_LIMIT  = 2000;

	logic                      clk;
	logic                      rst_n;
	adc_word_t                 adc_tdata [ADC_CHANNELS];
	logic [ADC_CHANNELS-1:0]   adc_tvalid;
	adc_word_t                 adc_data [ADC_CHANNELS];
	adc_word_t                 rms_r;
	adc_word_t                 rms_s;
	adc_word_t                 rms_t;
	logic [2:0]                rms_valid;
	adc_word_t                 set_c;
	adc_word_t                 set_v;
	logic [AXI_ADDR_WIDTH-1:0] awaddr;
	logic                      awvalid;
	logic                      awready;
	adc_word_t                 wdata;
	logic [AXI_STRB_WIDTH-1:0] wstrb;
	logic                      wvalid;
	logic                      wready;
	logic [1:0]                bresp;
	logic                      bvalid;
	logic                      bready;
	logic [AXI_ADDR_WIDTH-1:0] araddr;
	logic                      arvalid;
	logic                      arready;
	adc_word_t                 rdata;
	logic [1:0]                rresp;
	logic                      rvalid;
	logic                      rready;

	logic [31:0] lfsr_state;
	int          value_errors;
	int          other_errors;

	// Model of what the DUT should hold
	adc_word_t adc_model [ADC_CHANNELS];
	adc_word_t set_c_model;
	adc_word_t set_v_model;
	adc_word_t rms_model [3];
	adc_word_t rms_exp_q [3][$];

	tb_clock_gen u_clock_gen (.o_clk(clk), .o_rst_n(rst_n));

	mps_core_top i_mps_core_top
	(
		.s00_axi_aclk      (clk),
		.s00_axi_aresetn   (rst_n),
		.i_adc_tdata       (adc_tdata),
		.i_adc_tvalid      (adc_tvalid),
		.o_adc_data        (adc_data),
		.o_phase_rms_r     (rms_r),
		.o_phase_rms_s     (rms_s),
		.o_phase_rms_t     (rms_t),
		.o_phase_rms_valid (rms_valid),
		.o_set_c           (set_c),
		.o_set_v           (set_v),
		.i_s00_axi_awaddr  (awaddr),
		.i_s00_axi_awprot  (3'b000),
		.i_s00_axi_awvalid (awvalid),
		.o_s00_axi_awready (awready),
		.i_s00_axi_wdata   (wdata),
		.i_s00_axi_wstrb   (wstrb),
		.i_s00_axi_wvalid  (wvalid),
		.o_s00_axi_wready  (wready),
		.o_s00_axi_bresp   (bresp),
		.o_s00_axi_bvalid  (bvalid),
		.i_s00_axi_bready  (bready),
		.i_s00_axi_araddr  (araddr),
		.i_s00_axi_arprot  (3'b000),
		.i_s00_axi_arvalid (arvalid),
		.o_s00_axi_arready (arready),
		.o_s00_axi_rdata   (rdata),
		.o_s00_axi_rresp   (rresp),
		.o_s00_axi_rvalid  (rvalid),
		.i_s00_axi_rready  (rready)
	);

	bind mps_core_top mps_core_sva u_mps_core_sva
	(
		.s00_axi_aclk      (s00_axi_aclk),
		.s00_axi_aresetn   (s00_axi_aresetn),
		.o_s00_axi_awready (o_s00_axi_awready),
		.o_s00_axi_bvalid  (o_s00_axi_bvalid),
		.i_s00_axi_bready  (i_s00_axi_bready),
		.o_s00_axi_rvalid  (o_s00_axi_rvalid),
		.i_s00_axi_rready  (i_s00_axi_rready),
		.o_s00_axi_rdata   (o_s00_axi_rdata),
		.o_phase_rms_valid (o_phase_rms_valid)
	);

	////////////////////////////////////////////////////////////////////////////
	// Random bits and reference models
	////////////////////////////////////////////////////////////////////////////
	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r          = {r[30:0], fb};
		end
		return r;
	endfunction

	// Floor root of the window mean, found bit by bit from the top
	function automatic adc_word_t ref_rms(input adc_word_t samples [64]);
		longint unsigned sum;
		longint unsigned mean;
		longint unsigned cand;
		longint unsigned root;
		sum  = 0;
		root = 0;
		for (int i = 0; i < 64; i++)
			sum += longint'($signed(samples[i])) * longint'($signed(samples[i]));
		mean = sum >> 6;
		for (int b = 31; b >= 0; b--)
		begin
			cand = root | (64'd1 << b);
			if (cand * cand <= mean)
				root = cand;
		end
		return adc_word_t'(root);
	endfunction

	function automatic adc_word_t ref_reg(input int index);
		if (index == 0)
			return set_c_model;
		if (index == 1)
			return set_v_model;
		if (index >= 16 && index < 16 + ADC_CHANNELS)
			return adc_model[index - 16];
		if (index >= 32 && index <= 34)
			return rms_model[index - 32];
		return '0;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////
	task automatic check_adc(input string name, input adc_word_t got, input adc_word_t exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_rms(input string name, input adc_word_t got, input adc_word_t exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("FAILED %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_rdata(input string name, input adc_word_t got, input adc_word_t exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("FAILED %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("FAILED %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// AXI4-Lite host
	////////////////////////////////////////////////////////////////////////////
	task automatic axi_write(input int index, input adc_word_t data, input logic [3:0] strb,
		input bit leave_resp);
		int n;
		int hold;
		awaddr  = AXI_ADDR_WIDTH'(index << 2);
		wdata   = data;
		wstrb   = strb;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		// Previous response still waits, so this write must not be taken yet
		if (bvalid)
		begin
			hold = int'(rand_bits(3)) + 1;
			repeat (hold)
			begin
				@(negedge clk);
				if (awready)
				begin
					other_errors++;
					$display("Write to index %0d accepted while a response was pending",
						index);
				end
				if (!bvalid)
				begin
					other_errors++;
					$display("Pending write response dropped before it was taken");
				end
			end
			step();
			bready = 1'b1;
			step();
			bready = 1'b0;
		end
		n = 0;
		@(negedge clk);
		while (!awready && n < WAIT_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		if (!awready)
		begin
			other_errors++;
			$display("Write to index %0d was never accepted", index);
		end
		else
			check_bit("o_s00_axi_wready", wready, 1'b1);
		step();
		awvalid = 1'b0;
		wvalid  = 1'b0;
		n       = 0;
		@(negedge clk);
		while (!bvalid && n < WAIT_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		if (!bvalid)
		begin
			other_errors++;
			$display("No write response for index %0d", index);
		end
		else
			check_resp("o_s00_axi_bresp", bresp, 2'b00);
		if (!leave_resp)
		begin
			hold = int'(rand_bits(3));		// Back-pressure cycles
			repeat (hold)
			begin
				@(negedge clk);
				if (!bvalid)
				begin
					other_errors++;
					$display("Write response for index %0d dropped before it was taken",
						index);
				end
			end
			step();
			bready = 1'b1;
			step();
			bready = 1'b0;
		end
		else
			step();
	endtask

	task automatic axi_read(input int index, output adc_word_t data);
		int n;
		int hold;
		araddr  = AXI_ADDR_WIDTH'(index << 2);
		arvalid = 1'b1;
		n       = 0;
		@(negedge clk);
		while (!arready && n < WAIT_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		if (!arready)
		begin
			other_errors++;
			$display("Read of index %0d was never accepted", index);
		end
		step();
		arvalid = 1'b0;
		n       = 0;
		@(negedge clk);
		while (!rvalid && n < WAIT_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		if (!rvalid)
		begin
			other_errors++;
			$display("No read data for index %0d", index);
		end
		else
			check_resp("o_s00_axi_rresp", rresp, 2'b00);
		data = rdata;
		hold = int'(rand_bits(3));		// Back-pressure cycles
		repeat (hold)
		begin
			@(negedge clk);
			if (!rvalid || rdata !== data)
			begin
				other_errors++;
				$display("Read data for index %0d changed before it was taken", index);
			end
		end
		step();
		rready = 1'b1;
		step();
		rready = 1'b0;
	endtask

	task automatic read_and_check(input int index);
		adc_word_t got;
		axi_read(index, got);
		check_rdata($sformatf("rdata[%0d]", index), got, ref_reg(index));
	endtask

	// Pops one expected value for every RMS pulse
	always @(negedge clk)
	begin
		if (rst_n)
		begin
			for (int p = 0; p < 3; p++)
			begin
				if (rms_valid[p])
				begin
					if (rms_exp_q[p].size() == 0)
					begin
						other_errors++;
						$display("RMS pulse on phase %0d with no window pending", p);
					end
					else if (p == 0)
						check_rms("o_phase_rms_r", rms_r, rms_exp_q[0].pop_front());
					else if (p == 1)
						check_rms("o_phase_rms_s", rms_s, rms_exp_q[1].pop_front());
					else
						check_rms("o_phase_rms_t", rms_t, rms_exp_q[2].pop_front());
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////
	task automatic run_rms_windows(input int windows);
		adc_word_t   win [3][64];
		adc_word_t   s;
		logic [15:0] r16;
		int          n;
		for (int w = 0; w < windows; w++)
		begin
			for (int i = 0; i < 64; i++)
			begin
				for (int p = 0; p < 3; p++)
				begin
					r16       = 16'(rand_bits(16));
					s         = {{16{r16[15]}}, r16};	// Signed, bounded amplitude
					win[p][i] = s;
					adc_tdata[int'(CH_PHASE_R) + p] = s;
					adc_model[int'(CH_PHASE_R) + p] = s;
				end
				adc_tvalid = '0;
				adc_tvalid[CH_PHASE_R] = 1'b1;
				adc_tvalid[CH_PHASE_S] = 1'b1;
				adc_tvalid[CH_PHASE_T] = 1'b1;
				step();
			end
			for (int p = 0; p < 3; p++)
			begin
				rms_model[p] = ref_rms(win[p]);
				rms_exp_q[p].push_back(rms_model[p]);
			end
		end
		adc_tvalid = '0;
		n = 0;
		while ((rms_exp_q[0].size() + rms_exp_q[1].size() + rms_exp_q[2].size()) != 0
			&& n < RMS_LIMIT)
		begin
			step();
			n++;
		end
		if (n >= RMS_LIMIT)
		begin
			other_errors++;
			$display("RMS results missing after window end");
		end
	endtask

	initial
	begin
		adc_word_t  d;
		logic [3:0] strb;
		int         n;

		lfsr_state   = 32'hde0b_3659;
		value_errors = 0;
		other_errors = 0;
		adc_tvalid   = '0;
		awaddr       = '0;
		awvalid      = 1'b0;
		wdata        = '0;
		wstrb        = '0;
		wvalid       = 1'b0;
		bready       = 1'b0;
		araddr       = '0;
		arvalid      = 1'b0;
		rready       = 1'b0;
		set_c_model  = '0;
		set_v_model  = '0;
		for (int ch = 0; ch < ADC_CHANNELS; ch++)
		begin
			adc_tdata[ch] = '0;
			adc_model[ch] = '0;
		end
		for (int p = 0; p < 3; p++)
			rms_model[p] = '0;

		n = 0;
		while (!rst_n && n < WAIT_LIMIT)
		begin
			step();
			n++;
		end
		if (!rst_n)
		begin
			other_errors++;
			$display("Reset was never released");
		end
		step();

		// Reset values
		check_bit("o_s00_axi_awready", awready, 1'b0);
		check_bit("o_s00_axi_wready", wready, 1'b0);
		check_bit("o_s00_axi_bvalid", bvalid, 1'b0);
		check_bit("o_s00_axi_arready", arready, 1'b0);
		check_bit("o_s00_axi_rvalid", rvalid, 1'b0);
		check_adc("o_phase_rms_valid", adc_word_t'(rms_valid), '0);
		check_adc("o_set_c", set_c, '0);
		check_adc("o_set_v", set_v, '0);
		for (int ch = 0; ch < ADC_CHANNELS; ch++)
			check_adc($sformatf("o_adc_data[%0d]", ch), adc_data[ch], '0);

		// Two rounds of back-to-back windows per phase
		run_rms_windows(2);
		run_rms_windows(2);

		// Capture, few enough strobes that no RMS window completes
		for (int it = 0; it < 40; it++)
		begin
			for (int ch = 0; ch < ADC_CHANNELS; ch++)
				adc_tdata[ch] = rand_bits(32);
			adc_tvalid = ADC_CHANNELS'(rand_bits(ADC_CHANNELS));
			for (int ch = 0; ch < ADC_CHANNELS; ch++)
			begin
				if (adc_tvalid[ch])
					adc_model[ch] = adc_tdata[ch];
			end
			step();
			for (int ch = 0; ch < ADC_CHANNELS; ch++)
				check_adc($sformatf("o_adc_data[%0d]", ch), adc_data[ch], adc_model[ch]);
		end
		adc_tvalid = '0;

		// Set-points with byte strobes, some responses left waiting for the next write
		for (int it = 0; it < 8; it++)
		begin
			d    = rand_bits(32);
			strb = 4'(rand_bits(4));
			for (int b = 0; b < 4; b++)
			begin
				if (strb[b] && it[0] == 1'b0)
					set_c_model[b*8 +: 8] = d[b*8 +: 8];
				if (strb[b] && it[0] == 1'b1)
					set_v_model[b*8 +: 8] = d[b*8 +: 8];
			end
			axi_write(it[0] ? int'(REG_SET_V) : int'(REG_SET_C), d, strb, it[1]);
			check_adc("o_set_c", set_c, set_c_model);
			check_adc("o_set_v", set_v, set_v_model);
			read_and_check(REG_SET_C);
			read_and_check(REG_SET_V);
		end
		axi_write(5, rand_bits(32), 4'hf, 1'b0);
		check_adc("o_set_c", set_c, set_c_model);
		check_adc("o_set_v", set_v, set_v_model);
		read_and_check(5);
		read_and_check(40);

		// Measurement read-back
		for (int idx = 16; idx < 16 + ADC_CHANNELS; idx++)
			read_and_check(idx);
		for (int idx = 32; idx <= 34; idx++)
			read_and_check(idx);

		repeat (4) step();
		$display("Errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen
(
	output logic o_clk,
	output logic o_rst_n
);

	localparam realtime HALF_PERIOD = 4ns;	// 8 ns clock
	localparam int      RESET_CYCLES = 10;

	initial
	begin
		o_clk = 1'b0;
		forever #(HALF_PERIOD) o_clk = ~o_clk;
	end

	initial
	begin
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		#1 o_rst_n = 1'b1;
	end

endmodule

// File: logic/adc_capture.sv
`timescale 1ns/100ps

module adc_capture
	import mps_pkg::*;
(
	input  logic                    s00_axi_aclk,
	input  logic                    s00_axi_aresetn,

	input  adc_word_t               i_adc_tdata [ADC_CHANNELS],
	input  logic [ADC_CHANNELS-1:0] i_adc_tvalid,

	output adc_word_t               o_adc_data [ADC_CHANNELS],
	output logic [ADC_CHANNELS-1:0] o_sample_strobe		// Same cycle as new word
);

	// Hold register per channel, reloaded on its tvalid
	always_ff @(posedge s00_axi_aclk or negedge s00_axi_aresetn)
	begin
		if (!s00_axi_aresetn)
		begin
			for (int ch = 0; ch < ADC_CHANNELS; ch++)
			begin
				o_adc_data[ch] <= '0;
			end
		end
		else
		begin
			for (int ch = 0; ch < ADC_CHANNELS; ch++)
			begin
				if (i_adc_tvalid[ch])
					o_adc_data[ch] <= i_adc_tdata[ch];
			end
		end
	end

	// Strobe marks the cycle the held word changes
	always_ff @(posedge s00_axi_aclk or negedge s00_axi_aresetn)
	begin
		if (!s00_axi_aresetn)
			o_sample_strobe <= '0;
		else
			o_sample_strobe <= i_adc_tvalid;
	end

endmodule

// File: logic/axi_lite_regs.sv
`timescale 1ns/100ps

module axi_lite_regs
	import mps_pkg::*;
(
	input  logic                      s00_axi_aclk,
	input  logic                      s00_axi_aresetn,

	input  adc_word_t                 i_adc_data [ADC_CHANNELS],
	input  adc_word_t                 i_rms_r,
	input  adc_word_t                 i_rms_s,
	input  adc_word_t                 i_rms_t,

	output adc_word_t                 o_set_c,
	output adc_word_t                 o_set_v,

	input  logic [AXI_ADDR_WIDTH-1:0] i_s00_axi_awaddr,
	input  logic [2:0]                i_s00_axi_awprot,	// Not used
	input  logic                      i_s00_axi_awvalid,
	output logic                      o_s00_axi_awready,
	input  adc_word_t                 i_s00_axi_wdata,
	input  logic [AXI_STRB_WIDTH-1:0] i_s00_axi_wstrb,
	input  logic                      i_s00_axi_wvalid,
	output logic                      o_s00_axi_wready,
	output logic [1:0]                o_s00_axi_bresp,
	output logic                      o_s00_axi_bvalid,
	input  logic                      i_s00_axi_bready,
	input  logic [AXI_ADDR_WIDTH-1:0] i_s00_axi_araddr,
	input  logic [2:0]                i_s00_axi_arprot,	// Not used
	input  logic                      i_s00_axi_arvalid,
	output logic                      o_s00_axi_arready,
	output adc_word_t                 o_s00_axi_rdata,
	output logic [1:0]                o_s00_axi_rresp,
	output logic                      o_s00_axi_rvalid,
	input  logic                      i_s00_axi_rready
);

	logic                       wr_ready;		// Shared AWREADY/WREADY
	logic                       wr_en;
	reg_index_e                 wr_index;
	logic                       rd_ready;
	logic                       rd_en;
	reg_index_e                 rd_index;
	logic [AXI_INDEX_WIDTH-1:0] adc_off;
	adc_chan_e                  adc_sel;
	adc_word_t                  rd_mux;

	////////////////////////////////////////////////////////////////////////////
	// Write channel
	////////////////////////////////////////////////////////////////////////////
	assign wr_en    = wr_ready && i_s00_axi_awvalid && i_s00_axi_wvalid;
	assign wr_index = reg_index_e'(i_s00_axi_awaddr[AXI_ADDR_WIDTH-1:2]);	// Word index

	always_ff @(posedge s00_axi_aclk or negedge s00_axi_aresetn)
	begin
		if (!s00_axi_aresetn)
		begin
			wr_ready         <= 1'b0;
			o_s00_axi_bvalid <= 1'b0;
		end
		else
		begin
			// Single cycle ready, blocked while a response is pending
			wr_ready <= i_s00_axi_awvalid && i_s00_axi_wvalid && !wr_ready && !o_s00_axi_bvalid;
			if (wr_en)
				o_s00_axi_bvalid <= 1'b1;
			else if (i_s00_axi_bready)
				o_s00_axi_bvalid <= 1'b0;
		end
	end

	// Set-points, byte lanes under WSTRB
	always_ff @(posedge s00_axi_aclk or negedge s00_axi_aresetn)
	begin
		if (!s00_axi_aresetn)
		begin
			o_set_c <= '0;
			o_set_v <= '0;
		end
		else if (wr_en)
		begin
			for (int b = 0; b < AXI_STRB_WIDTH; b++)
			begin
				if (i_s00_axi_wstrb[b] && wr_index == REG_SET_C)
					o_set_c[b*8 +: 8] <= i_s00_axi_wdata[b*8 +: 8];
				if (i_s00_axi_wstrb[b] && wr_index == REG_SET_V)
					o_set_v[b*8 +: 8] <= i_s00_axi_wdata[b*8 +: 8];
			end
		end
	end

	assign o_s00_axi_awready = wr_ready;
	assign o_s00_axi_wready  = wr_ready;
	assign o_s00_axi_bresp   = AXI_RESP_OKAY;

	////////////////////////////////////////////////////////////////////////////
	// Read channel
	////////////////////////////////////////////////////////////////////////////
	assign rd_en    = rd_ready && i_s00_axi_arvalid;
	assign rd_index = reg_index_e'(i_s00_axi_araddr[AXI_ADDR_WIDTH-1:2]);
	assign adc_off  = rd_index - REG_ADC_BASE;
	assign adc_sel  = adc_chan_e'(adc_off[ADC_SEL_WIDTH-1:0]);

	always_comb
	begin
		rd_mux = '0;								// Unmapped reads zero
		case (rd_index)
			REG_SET_C: rd_mux = o_set_c;
			REG_SET_V: rd_mux = o_set_v;
			REG_RMS_R: rd_mux = i_rms_r;
			REG_RMS_S: rd_mux = i_rms_s;
			REG_RMS_T: rd_mux = i_rms_t;
			default:
			begin
				if (rd_index >= REG_ADC_BASE && adc_off < AXI_INDEX_WIDTH'(ADC_CHANNELS))
					rd_mux = i_adc_data[adc_sel];
			end
		endcase
	end

	always_ff @(posedge s00_axi_aclk or negedge s00_axi_aresetn)
	begin
		if (!s00_axi_aresetn)
		begin
			rd_ready         <= 1'b0;
			o_s00_axi_rvalid <= 1'b0;
		end
		else
		begin
			rd_ready <= i_s00_axi_arvalid && !rd_ready && !o_s00_axi_rvalid;
			if (rd_en)
				o_s00_axi_rvalid <= 1'b1;
			else if (i_s00_axi_rready)
				o_s00_axi_rvalid <= 1'b0;
		end
	end

	// Data held until RREADY since no new read is taken meanwhile
	always_ff @(posedge s00_axi_aclk)
	begin
		if (rd_en)
			o_s00_axi_rdata <= rd_mux;
	end

	assign o_s00_axi_arready = rd_ready;
	assign o_s00_axi_rresp   = AXI_RESP_OKAY;

endmodule

// File: logic/mps_core_top.sv
`timescale 1ns/100ps

module mps_core_top
	import mps_pkg::*;
(
	input  logic                      s00_axi_aclk,
	input  logic                      s00_axi_aresetn,

	// ADC inputs, indexed by adc_chan_e
	input  adc_word_t                 i_adc_tdata [ADC_CHANNELS],
	input  logic [ADC_CHANNELS-1:0]   i_adc_tvalid,

	output adc_word_t                 o_adc_data [ADC_CHANNELS],
	output adc_word_t                 o_phase_rms_r,
	output adc_word_t                 o_phase_rms_s,
	output adc_word_t                 o_phase_rms_t,
	output logic [2:0]                o_phase_rms_valid,	// R, S, T

	output adc_word_t                 o_set_c,
	output adc_word_t                 o_set_v,

	// AXI4-Lite slave
	input  logic [AXI_ADDR_WIDTH-1:0] i_s00_axi_awaddr,
	input  logic [2:0]                i_s00_axi_awprot,
	input  logic                      i_s00_axi_awvalid,
	output logic                      o_s00_axi_awready,
	input  adc_word_t                 i_s00_axi_wdata,
	input  logic [AXI_STRB_WIDTH-1:0] i_s00_axi_wstrb,
	input  logic                      i_s00_axi_wvalid,
	output logic                      o_s00_axi_wready,
	output logic [1:0]                o_s00_axi_bresp,
	output logic                      o_s00_axi_bvalid,
	input  logic                      i_s00_axi_bready,
	input  logic [AXI_ADDR_WIDTH-1:0] i_s00_axi_araddr,
	input  logic [2:0]                i_s00_axi_arprot,
	input  logic                      i_s00_axi_arvalid,
	output logic                      o_s00_axi_arready,
	output adc_word_t                 o_s00_axi_rdata,
	output logic [1:0]                o_s00_axi_rresp,
	output logic                      o_s00_axi_rvalid,
	input  logic                      i_s00_axi_rready
);

	logic [ADC_CHANNELS-1:0] sample_strobe;

	////////////////////////////////////////////////////////////////////////////
	// Capture and phase RMS
	////////////////////////////////////////////////////////////////////////////
	adc_capture u_adc_capture
	(
		.s00_axi_aclk    (s00_axi_aclk),
		.s00_axi_aresetn (s00_axi_aresetn),
		.i_adc_tdata     (i_adc_tdata),
		.i_adc_tvalid    (i_adc_tvalid),
		.o_adc_data      (o_adc_data),
		.o_sample_strobe (sample_strobe)
	);

	phase_rms u_phase_rms_r
	(
		.s00_axi_aclk    (s00_axi_aclk),
		.s00_axi_aresetn (s00_axi_aresetn),
		.i_sample        (o_adc_data[CH_PHASE_R]),
		.i_sample_strobe (sample_strobe[CH_PHASE_R]),
		.o_rms           (o_phase_rms_r),
		.o_rms_valid     (o_phase_rms_valid[0])
	);

	phase_rms u_phase_rms_s
	(
		.s00_axi_aclk    (s00_axi_aclk),
		.s00_axi_aresetn (s00_axi_aresetn),
		.i_sample        (o_adc_data[CH_PHASE_S]),
		.i_sample_strobe (sample_strobe[CH_PHASE_S]),
		.o_rms           (o_phase_rms_s),
		.o_rms_valid     (o_phase_rms_valid[1])
	);

	phase_rms u_phase_rms_t
	(
		.s00_axi_aclk    (s00_axi_aclk),
		.s00_axi_aresetn (s00_axi_aresetn),
		.i_sample        (o_adc_data[CH_PHASE_T]),
		.i_sample_strobe (sample_strobe[CH_PHASE_T]),
		.o_rms           (o_phase_rms_t),
		.o_rms_valid     (o_phase_rms_valid[2])
	);

	////////////////////////////////////////////////////////////////////////////
	// Host register block
	////////////////////////////////////////////////////////////////////////////
	axi_lite_regs u_axi_lite_regs
	(
		.s00_axi_aclk      (s00_axi_aclk),
		.s00_axi_aresetn   (s00_axi_aresetn),
		.i_adc_data        (o_adc_data),
		.i_rms_r           (o_phase_rms_r),
		.i_rms_s           (o_phase_rms_s),
		.i_rms_t           (o_phase_rms_t),
		.o_set_c           (o_set_c),
		.o_set_v           (o_set_v),
		.i_s00_axi_awaddr  (i_s00_axi_awaddr),
		.i_s00_axi_awprot  (i_s00_axi_awprot),
		.i_s00_axi_awvalid (i_s00_axi_awvalid),
		.o_s00_axi_awready (o_s00_axi_awready),
		.i_s00_axi_wdata   (i_s00_axi_wdata),
		.i_s00_axi_wstrb   (i_s00_axi_wstrb),
		.i_s00_axi_wvalid  (i_s00_axi_wvalid),
		.o_s00_axi_wready  (o_s00_axi_wready),
		.o_s00_axi_bresp   (o_s00_axi_bresp),
		.o_s00_axi_bvalid  (o_s00_axi_bvalid),
		.i_s00_axi_bready  (i_s00_axi_bready),
		.i_s00_axi_araddr  (i_s00_axi_araddr),
		.i_s00_axi_arprot  (i_s00_axi_arprot),
		.i_s00_axi_arvalid (i_s00_axi_arvalid),
		.o_s00_axi_arready (o_s00_axi_arready),
		.o_s00_axi_rdata   (o_s00_axi_rdata),
		.o_s00_axi_rresp   (o_s00_axi_rresp),
		.o_s00_axi_rvalid  (o_s00_axi_rvalid),
		.i_s00_axi_rready  (i_s00_axi_rready)
	);

endmodule

// File: logic/mps_pkg.sv
package mps_pkg;

	////////////////////////////////////////////////////////////////////////////
	// ADC words and channels
	////////////////////////////////////////////////////////////////////////////
	localparam int ADC_WIDTH     = 32;				// ADC and register width
	localparam int ADC_CHANNELS  = 10;
	localparam int ADC_SEL_WIDTH = $clog2(ADC_CHANNELS);

	typedef logic [ADC_WIDTH-1:0] adc_word_t;		// Signed for the RMS units

	// Channel order of the capture array
	typedef enum logic [ADC_SEL_WIDTH-1:0] {
		CH_C         = 0,						// Load current
		CH_V         = 1,						// Load voltage
		CH_DC_V      = 2,
		CH_PHASE_R   = 3,
		CH_PHASE_S   = 4,
		CH_PHASE_T   = 5,
		CH_DC_C      = 6,
		CH_IGBT_T    = 7,
		CH_IN_IND_T  = 8,						// Input inductor temp
		CH_OUT_IND_T = 9						// Output inductor temp
	} adc_chan_e;

	////////////////////////////////////////////////////////////////////////////
	// AXI4-Lite register map
	////////////////////////////////////////////////////////////////////////////
	localparam int AXI_ADDR_NUM    = 128;
	localparam int AXI_INDEX_WIDTH = $clog2(AXI_ADDR_NUM);
	localparam int AXI_ADDR_WIDTH  = AXI_INDEX_WIDTH + 2;	// Byte address
	localparam int AXI_STRB_WIDTH  = ADC_WIDTH / 8;

	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

	typedef enum logic [AXI_INDEX_WIDTH-1:0] {
		REG_SET_C    = 0,						// Read/write
		REG_SET_V    = 1,
		REG_ADC_BASE = 16,						// 16..25 held ADC words
		REG_RMS_R    = 32,
		REG_RMS_S    = 33,
		REG_RMS_T    = 34
	} reg_index_e;

	////////////////////////////////////////////////////////////////////////////
	// Phase RMS
	////////////////////////////////////////////////////////////////////////////
	localparam int RMS_WINDOW_LOG2 = 6;			// 64 samples per window
	localparam int RMS_SUM_WIDTH   = 70;
	localparam int RMS_MEAN_WIDTH  = 64;
	localparam int RMS_ROOT_WIDTH  = RMS_MEAN_WIDTH / 2;
	localparam int RMS_REM_WIDTH   = RMS_ROOT_WIDTH + 4;

	typedef enum logic [1:0] {RMS_IDLE, RMS_ROOT, RMS_DONE} rms_state_e;

endpackage

// File: logic/phase_rms.sv
`timescale 1ns/100ps

module phase_rms
	import mps_pkg::*;
(
	input  logic      s00_axi_aclk,
	input  logic      s00_axi_aresetn,

	input  adc_word_t i_sample,					// Signed phase sample
	input  logic      i_sample_strobe,

	output adc_word_t o_rms,
	output logic      o_rms_valid				// One cycle per new result
);

	logic [RMS_MEAN_WIDTH-1:0]  sample_ext;
	logic [RMS_MEAN_WIDTH-1:0]  sample_sq;
	logic                       sq_valid;
	logic [RMS_SUM_WIDTH-1:0]   sum_sq;
	logic [RMS_SUM_WIDTH-1:0]   sum_next;
	logic [RMS_WINDOW_LOG2-1:0] win_cnt;
	logic                       win_end;
	logic [RMS_MEAN_WIDTH-1:0]  mean_sq;
	logic                       mean_ready;

	rms_state_e                 state;
	logic [RMS_MEAN_WIDTH-1:0]  radicand;
	logic [RMS_REM_WIDTH-1:0]   remainder;
	logic [RMS_REM_WIDTH-1:0]   rem_shift;
	logic [RMS_REM_WIDTH-1:0]   trial;
	logic [RMS_ROOT_WIDTH-1:0]  root;
	logic [$clog2(RMS_ROOT_WIDTH)-1:0] bit_cnt;

	////////////////////////////////////////////////////////////////////////////
	// Square and accumulate
	////////////////////////////////////////////////////////////////////////////
	// Sample sign extended to the square width
	assign sample_ext = {{(RMS_MEAN_WIDTH-ADC_WIDTH){i_sample[ADC_WIDTH-1]}}, i_sample};

	always_ff @(posedge s00_axi_aclk)
	begin
		sample_sq <= $signed(sample_ext) * $signed(sample_ext);	// Always positive
	end

	assign sum_next = sum_sq + RMS_SUM_WIDTH'(sample_sq);
	assign win_end  = sq_valid && (&win_cnt);				// 64th square of window

	always_ff @(posedge s00_axi_aclk or negedge s00_axi_aresetn)
	begin
		if (!s00_axi_aresetn)
		begin
			sq_valid   <= 1'b0;
			sum_sq     <= '0;
			win_cnt    <= '0;
			mean_ready <= 1'b0;
		end
		else
		begin
			sq_valid   <= i_sample_strobe;
			mean_ready <= win_end;
			if (sq_valid)
			begin
				win_cnt <= win_cnt + 1'b1;		// Wraps into next window
				sum_sq  <= win_end ? '0 : sum_next;
			end
		end
	end

	// Divide by 64 is a plain shift
	always_ff @(posedge s00_axi_aclk)
	begin
		if (win_end)
			mean_sq <= sum_next[RMS_SUM_WIDTH-1:RMS_WINDOW_LOG2];
	end

	////////////////////////////////////////////////////////////////////////////
	// Bit-serial square root, two radicand bits per cycle
	////////////////////////////////////////////////////////////////////////////
	assign rem_shift = {remainder[RMS_REM_WIDTH-3:0], radicand[RMS_MEAN_WIDTH-1 -: 2]};
	assign trial     = RMS_REM_WIDTH'({root, 2'b01});

	always_ff @(posedge s00_axi_aclk or negedge s00_axi_aresetn)
	begin
		if (!s00_axi_aresetn)
		begin
			state       <= RMS_IDLE;
			bit_cnt     <= '0;
			o_rms       <= '0;
			o_rms_valid <= 1'b0;
		end
		else
		begin
			o_rms_valid <= 1'b0;
			case (state)
				RMS_IDLE:
				begin
					bit_cnt <= '0;
					if (mean_ready)
						state <= RMS_ROOT;
				end
				RMS_ROOT:
				begin
					bit_cnt <= bit_cnt + 1'b1;
					if (&bit_cnt)
						state <= RMS_DONE;	// 32 iterations done
				end
				RMS_DONE:
				begin
					o_rms       <= root;
					o_rms_valid <= 1'b1;
					state       <= RMS_IDLE;
				end
				default: state <= RMS_IDLE;
			endcase
		end
	end

	always_ff @(posedge s00_axi_aclk)
	begin
		if (state == RMS_IDLE && mean_ready)
		begin
			radicand  <= mean_sq;
			remainder <= '0;
			root      <= '0;
		end
		else if (state == RMS_ROOT)
		begin
			radicand <= radicand << 2;
			if (rem_shift >= trial)
			begin
				remainder <= rem_shift - trial;
				root      <= {root[RMS_ROOT_WIDTH-2:0], 1'b1};
			end
			else
			begin
				remainder <= rem_shift;
				root      <= {root[RMS_ROOT_WIDTH-2:0], 1'b0};
			end
		end
	end

endmodule

// File: project.f
logic/mps_pkg.sv
logic/adc_capture.sv
logic/phase_rms.sv
logic/axi_lite_regs.sv
logic/mps_core_top.sv
dv/tb_clock_gen.sv
dv/mps_core_sva.sv
dv/mps_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f \
	--top-module mps_core_tb -o mps_core_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/mps_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Verification passed" "$LOG"; then
	exit 0
fi
exit 1
